// ==== source/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store slice sizing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// integer register and data path width.
`define LSU_XLEN 64

// rank bits appended below the architectural register number.
`define LSU_RB 1

// entries in the issue queue, a power of two.
`define LSU_FIFO_DP 4

// doubleword address bits of the data memory.
`define LSU_MEM_AW 6

`endif

// ==== source/lsu_reg_pkg.sv ====
`include "lsu_consts.svh"

package lsu_reg_pkg;

	// one integer data word.
	typedef logic [`LSU_XLEN-1:0] xdata_t;

	// physical register index, rank in the low bits.
	typedef logic [5+`LSU_RB-1:0] preg_t;

	// one ready bit per physical register.
	typedef logic [2**$bits(preg_t)-1:0] ready_vec_t;

	// register write-back.
	typedef struct packed {
		logic   valid;
		preg_t  rd;
		xdata_t data;
	} wb_t;

	// x0 of any rank reads as zero and is always ready.
	function automatic logic is_x0(preg_t r);
		return r[`LSU_RB +: 5] == 5'd0;
	endfunction

endpackage

// ==== source/lsu_op_pkg.sv ====
`include "lsu_consts.svh"

package lsu_op_pkg;

	// doubleword index into the data memory.
	typedef logic [`LSU_MEM_AW-1:0] mem_addr_t;

	// one enable per byte of a data word.
	typedef logic [$bits(lsu_reg_pkg::xdata_t)/8-1:0] byte_mask_t;

	// decoded operation, exactly one flag set.
	typedef struct packed {
		logic lb;
		logic lh;
		logic lw;
		logic ld;
		logic lbu;
		logic lhu;
		logic lwu;
		logic sb;
		logic sh;
		logic sw;
		logic sd;
		logic fence_i;
		logic fence;
	} lsu_op_t;

	typedef struct packed {
		lsu_op_t               op;
		lsu_reg_pkg::xdata_t   imm;
		lsu_reg_pkg::preg_t    rd0;
		lsu_reg_pkg::preg_t    rs1;
		lsu_reg_pkg::preg_t    rs2;
	} lsu_issue_info_t;

	// op1 is the effective address, op2 the store data.
	typedef struct packed {
		lsu_op_t               op;
		lsu_reg_pkg::preg_t    rd0;
		lsu_reg_pkg::xdata_t   op1;
		lsu_reg_pkg::xdata_t   op2;
	} lsu_exe_info_t;

	typedef struct packed {
		logic                  valid;
		mem_addr_t             addr;
		lsu_reg_pkg::xdata_t   data;
		byte_mask_t            mask;
	} mem_write_t;

	typedef enum logic {
		idle,
		load_read
	} lsu_exec_state_t;

	function automatic logic is_load(lsu_op_t op);
		return op.lb | op.lh | op.lw | op.ld | op.lbu | op.lhu | op.lwu;
	endfunction

	function automatic logic is_store(lsu_op_t op);
		return op.sb | op.sh | op.sw | op.sd;
	endfunction

	function automatic logic is_fence(lsu_op_t op);
		return op.fence_i | op.fence;
	endfunction

endpackage

// ==== source/lsu_issue_fifo.sv ====
`include "lsu_consts.svh"

module lsu_issue_fifo (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic                        push,
	input  lsu_op_pkg::lsu_issue_info_t push_info,
	input  logic                        pop,
	input  logic                        flush,
	output lsu_op_pkg::lsu_issue_info_t head_info,
	output logic                        empty,
	output logic                        full
);

	localparam int DP = `LSU_FIFO_DP;
	localparam int AW = $clog2(DP);
	localparam logic [AW:0] DEPTH = (AW+1)'(DP);

	lsu_op_pkg::lsu_issue_info_t buffer [DP];
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr;
	logic [AW:0]   count;

	assign empty     = (count == '0);
	assign full      = (count == DEPTH);
	assign head_info = buffer[rd_ptr];

	// pointers wrap naturally since the depth is a power of two.
	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (push) begin
			buffer[wr_ptr] <= push_info;
		end
	end

endmodule

// ==== source/lsu_regfile.sv ====
module lsu_regfile (
	input  logic                    CLK,
	input  logic                    reset,
	input  logic                    alloc_valid,
	input  lsu_reg_pkg::preg_t      alloc_rd,
	input  lsu_reg_pkg::wb_t        load_wb,
	input  lsu_reg_pkg::wb_t        ext_wb,
	input  lsu_reg_pkg::preg_t      rs1,
	input  lsu_reg_pkg::preg_t      rs2,
	output lsu_reg_pkg::xdata_t     rs1_data,
	output lsu_reg_pkg::xdata_t     rs2_data,
	output lsu_reg_pkg::ready_vec_t ready_vec
);

	localparam int NREG = $bits(lsu_reg_pkg::ready_vec_t);

	lsu_reg_pkg::xdata_t     regs [NREG];
	lsu_reg_pkg::ready_vec_t wb_log;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data array.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// the load write-back is applied last, so it wins a same-register clash.
	always_ff @(posedge CLK) begin
		if (ext_wb.valid && !lsu_reg_pkg::is_x0(ext_wb.rd)) begin
			regs[ext_wb.rd] <= ext_wb.data;
		end
		if (load_wb.valid && !lsu_reg_pkg::is_x0(load_wb.rd)) begin
			regs[load_wb.rd] <= load_wb.data;
		end
	end

	assign rs1_data = lsu_reg_pkg::is_x0(rs1) ? '0 : regs[rs1];
	assign rs2_data = lsu_reg_pkg::is_x0(rs2) ? '0 : regs[rs2];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write-back log.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a new allocation outranks a write-back from an older producer.
	always_ff @(posedge CLK) begin
		if (reset) begin
			wb_log <= '1;
		end else begin
			if (ext_wb.valid) begin
				wb_log[ext_wb.rd] <= 1'b1;
			end
			if (load_wb.valid) begin
				wb_log[load_wb.rd] <= 1'b1;
			end
			if (alloc_valid && !lsu_reg_pkg::is_x0(alloc_rd)) begin
				wb_log[alloc_rd] <= 1'b0;
			end
		end
	end

	assign ready_vec = wb_log;

endmodule

// ==== source/lsu_issue.sv ====
module lsu_issue (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic                        flush,
	input  lsu_op_pkg::lsu_issue_info_t head_info,
	input  logic                        fifo_empty,
	output logic                        fifo_pop,
	input  lsu_reg_pkg::ready_vec_t     ready_vec,
	input  lsu_reg_pkg::xdata_t         rs1_data,
	input  lsu_reg_pkg::xdata_t         rs2_data,
	input  logic                        issue_ready,
	output logic                        issue_valid,
	output lsu_op_pkg::lsu_exe_info_t   issue_info
);

	lsu_op_pkg::lsu_op_t op;
	logic                is_load;
	logic                is_store;
	logic                is_fence;
	logic                rs1_ready;
	logic                rs2_ready;
	logic                clear_raw;
	logic                valid_set;
	logic                valid_rst;
	lsu_reg_pkg::xdata_t op1;
	lsu_reg_pkg::xdata_t op2;

	assign op       = head_info.op;
	assign is_load  = lsu_op_pkg::is_load(op);
	assign is_store = lsu_op_pkg::is_store(op);
	assign is_fence = lsu_op_pkg::is_fence(op);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand readiness.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign rs1_ready = ready_vec[head_info.rs1] | lsu_reg_pkg::is_x0(head_info.rs1);
	assign rs2_ready = ready_vec[head_info.rs2] | lsu_reg_pkg::is_x0(head_info.rs2);

	// fences carry no operands and go straight through.
	assign clear_raw = !fifo_empty && (
		(is_load && rs1_ready) ||
		(is_store && rs1_ready && rs2_ready) ||
		is_fence
	);

	// effective address and store data.
	assign op1 = rs1_data + head_info.imm;
	assign op2 = rs2_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// valid/ready issue register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// set and reset are exclusive, set needs valid low and no flush.
	assign valid_set = !flush && clear_raw && !issue_valid;
	assign valid_rst = flush || (issue_ready && issue_valid);
	assign fifo_pop  = valid_set;

	always_ff @(posedge CLK) begin
		if (reset) begin
			issue_valid <= 1'b0;
		end else if (valid_set) begin
			issue_valid <= 1'b1;
		end else if (valid_rst) begin
			issue_valid <= 1'b0;
		end
	end

	// info only loads on set, so it holds for the whole handshake.
	always_ff @(posedge CLK) begin
		if (valid_set) begin
			issue_info <= '{op: op, rd0: head_info.rd0, op1: op1, op2: op2};
		end
	end

endmodule

// ==== source/lsu_exec.sv ====
module lsu_exec (
	input  logic                      CLK,
	input  logic                      reset,
	input  logic                      issue_valid,
	input  lsu_op_pkg::lsu_exe_info_t issue_info,
	output logic                      issue_ready,
	output lsu_reg_pkg::wb_t          load_wb,
	output lsu_op_pkg::mem_write_t    mem_write
);

	localparam int WORDS = 2 ** $bits(lsu_op_pkg::mem_addr_t);
	localparam int NBYTE = $bits(lsu_op_pkg::byte_mask_t);

	lsu_op_pkg::lsu_exec_state_t state;
	lsu_reg_pkg::xdata_t         mem [WORDS];
	logic                        accept;
	logic [2:0]                  st_off;
	lsu_op_pkg::byte_mask_t      st_mask;
	lsu_reg_pkg::xdata_t         st_data;

	// load held between accept and memory read.
	lsu_op_pkg::lsu_op_t         ld_op;
	lsu_reg_pkg::preg_t          ld_rd;
	lsu_op_pkg::mem_addr_t       ld_addr;
	logic [2:0]                  ld_lo;
	logic [2:0]                  ld_off;
	lsu_reg_pkg::xdata_t         ld_shift;
	lsu_reg_pkg::xdata_t         ld_data;

	logic                        wb_valid;
	lsu_reg_pkg::preg_t          wb_rd;
	lsu_reg_pkg::xdata_t         wb_data;
	logic                        mw_valid;
	lsu_op_pkg::mem_addr_t       mw_addr;
	lsu_reg_pkg::xdata_t         mw_data;
	lsu_op_pkg::byte_mask_t      mw_mask;

	assign issue_ready = (state == lsu_op_pkg::idle);
	assign accept      = issue_valid && issue_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// size handling.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// address bits below the access size are dropped.
	always_comb begin
		st_off  = 3'd0;
		st_mask = 8'hff;
		if (issue_info.op.sb) begin
			st_off  = issue_info.op1[2:0];
			st_mask = 8'h01;
		end else if (issue_info.op.sh) begin
			st_off  = {issue_info.op1[2:1], 1'b0};
			st_mask = 8'h03;
		end else if (issue_info.op.sw) begin
			st_off  = {issue_info.op1[2], 2'b00};
			st_mask = 8'h0f;
		end
		st_mask = st_mask << st_off;
		st_data = issue_info.op2 << {st_off, 3'b000};
	end

	always_comb begin
		ld_off = ld_lo;
		if (ld_op.lh || ld_op.lhu) begin
			ld_off[0] = 1'b0;
		end else if (ld_op.lw || ld_op.lwu) begin
			ld_off[1:0] = 2'b00;
		end else if (ld_op.ld) begin
			ld_off = 3'd0;
		end
		ld_shift = mem[ld_addr] >> {ld_off, 3'b000};
		ld_data  = ld_shift;
		if (ld_op.lb) begin
			ld_data = {{56{ld_shift[7]}}, ld_shift[7:0]};
		end else if (ld_op.lh) begin
			ld_data = {{48{ld_shift[15]}}, ld_shift[15:0]};
		end else if (ld_op.lw) begin
			ld_data = {{32{ld_shift[31]}}, ld_shift[31:0]};
		end else if (ld_op.lbu) begin
			ld_data = {56'd0, ld_shift[7:0]};
		end else if (ld_op.lhu) begin
			ld_data = {48'd0, ld_shift[15:0]};
		end else if (ld_op.lwu) begin
			ld_data = {32'd0, ld_shift[31:0]};
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// state machine and output strobes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// fences are accepted in idle and leave no trace.
	always_ff @(posedge CLK) begin
		if (reset) begin
			state    <= lsu_op_pkg::idle;
			wb_valid <= 1'b0;
			mw_valid <= 1'b0;
		end else begin
			wb_valid <= 1'b0;
			mw_valid <= accept && lsu_op_pkg::is_store(issue_info.op);
			case (state)
				lsu_op_pkg::idle: begin
					if (accept && lsu_op_pkg::is_load(issue_info.op)) begin
						state <= lsu_op_pkg::load_read;
					end
				end
				default: begin
					state    <= lsu_op_pkg::idle;
					wb_valid <= !lsu_reg_pkg::is_x0(ld_rd);
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			ld_op   <= issue_info.op;
			ld_rd   <= issue_info.rd0;
			ld_addr <= issue_info.op1[3 +: $bits(lsu_op_pkg::mem_addr_t)];
			ld_lo   <= issue_info.op1[2:0];
			mw_addr <= issue_info.op1[3 +: $bits(lsu_op_pkg::mem_addr_t)];
			mw_data <= st_data;
			mw_mask <= st_mask;
		end
		if (state == lsu_op_pkg::load_read) begin
			wb_rd   <= ld_rd;
			wb_data <= ld_data;
		end
	end

	// memory takes the pending store one cycle after accept.
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (mw_valid) begin
			for (int b = 0; b < NBYTE; b++) begin
				if (mw_mask[b]) begin
					mem[mw_addr][b*8 +: 8] <= mw_data[b*8 +: 8];
				end
			end
		end
	end

	assign load_wb   = '{valid: wb_valid, rd: wb_rd, data: wb_data};
	assign mem_write = '{valid: mw_valid, addr: mw_addr, data: mw_data, mask: mw_mask};

endmodule

// ==== source/lsu_top.sv ====
module lsu_top (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic                        flush,
	input  logic                        dispatch_valid,
	input  lsu_op_pkg::lsu_issue_info_t dispatch_info,
	output logic                        dispatch_full,
	input  lsu_reg_pkg::wb_t            ext_wb,
	output lsu_reg_pkg::wb_t            load_wb,
	output lsu_op_pkg::mem_write_t      mem_write
);

	logic                        push;
	logic                        fifo_pop;
	logic                        fifo_empty;
	logic                        fifo_full;
	lsu_op_pkg::lsu_issue_info_t head_info;
	lsu_reg_pkg::xdata_t         rs1_data;
	lsu_reg_pkg::xdata_t         rs2_data;
	lsu_reg_pkg::ready_vec_t     ready_vec;
	logic                        issue_valid;
	logic                        issue_ready;
	lsu_op_pkg::lsu_exe_info_t   issue_info;

	// an accepted dispatch also allocates its destination.
	assign push          = dispatch_valid & ~fifo_full;
	assign dispatch_full = fifo_full;

	lsu_issue_fifo lsu_issue_fifo_inst (
		.CLK       (CLK),
		.reset     (reset),
		.push      (push),
		.push_info (dispatch_info),
		.pop       (fifo_pop),
		.flush     (flush),
		.head_info (head_info),
		.empty     (fifo_empty),
		.full      (fifo_full)
	);

	lsu_regfile lsu_regfile_inst (
		.CLK         (CLK),
		.reset       (reset),
		.alloc_valid (push),
		.alloc_rd    (dispatch_info.rd0),
		.load_wb     (load_wb),
		.ext_wb      (ext_wb),
		.rs1         (head_info.rs1),
		.rs2         (head_info.rs2),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.ready_vec   (ready_vec)
	);

	lsu_issue lsu_issue_inst (
		.CLK         (CLK),
		.reset       (reset),
		.flush       (flush),
		.head_info   (head_info),
		.fifo_empty  (fifo_empty),
		.fifo_pop    (fifo_pop),
		.ready_vec   (ready_vec),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.issue_ready (issue_ready),
		.issue_valid (issue_valid),
		.issue_info  (issue_info)
	);

	lsu_exec lsu_exec_inst (
		.CLK         (CLK),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue_info  (issue_info),
		.issue_ready (issue_ready),
		.load_wb     (load_wb),
		.mem_write   (mem_write)
	);

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock (
	output logic CLK
);

	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period.
	initial begin
		CLK = 1'b0;
	end

	always #20 CLK = ~CLK;

endmodule

// ==== testbench/lsu_assertions.sv ====
module lsu_assertions (
	input logic                      CLK,
	input logic                      reset,
	input logic                      flush,
	input logic                      issue_valid,
	input logic                      issue_ready,
	input lsu_op_pkg::lsu_exe_info_t issue_info,
	input logic                      fifo_pop,
	input logic                      fifo_empty,
	input lsu_reg_pkg::wb_t          load_wb,
	input lsu_op_pkg::mem_write_t    mem_write
);

	timeunit 1ns;
	timeprecision 1ps;

	// a stalled issue keeps its valid and its info.
	issue_hold_a: assert property (@(posedge CLK) disable iff (reset)
		issue_valid && !issue_ready && !flush |=> issue_valid && $stable(issue_info))
		else $error("issue register changed before issue_ready");

	pop_not_empty_a: assert property (@(posedge CLK) disable iff (reset)
		fifo_pop |-> !fifo_empty)
		else $error("queue popped while empty");

	quiet_in_reset_a: assert property (@(posedge CLK)
		reset && $past(reset) |-> !load_wb.valid && !mem_write.valid)
		else $error("output strobe during reset");

endmodule

bind lsu_top lsu_assertions lsu_assertions_inst (.*);

// ==== testbench/tb_checker.sv ====
`include "lsu_consts.svh"

module tb_checker (
	input  logic                        CLK,
	input  logic                        flush,
	input  logic                        dispatch_valid,
	input  logic                        dispatch_full,
	input  lsu_op_pkg::lsu_issue_info_t dispatch_info,
	input  lsu_reg_pkg::wb_t            ext_wb,
	input  logic                        issue_fire,
	input  lsu_reg_pkg::wb_t            load_wb,
	input  lsu_op_pkg::mem_write_t      mem_write,
	input  logic                        end_check,
	output logic                        busy,
	output int                          mismatch_count,
	output int                          missing_count
);

	timeunit 1ns;
	timeprecision 1ps;

	lsu_reg_pkg::xdata_t         regs [64];
	lsu_reg_pkg::xdata_t         mem [64];
	lsu_op_pkg::lsu_issue_info_t pending [$];
	lsu_reg_pkg::wb_t            exp_loads [$];
	lsu_op_pkg::mem_write_t      exp_stores [$];
	bit                          checked;

	initial begin
		foreach (regs[i]) regs[i] = '0;
		foreach (mem[i]) mem[i] = '0;
		busy           = 1'b0;
		mismatch_count = 0;
		missing_count  = 0;
		checked        = 0;
	end

	function automatic bit zero_reg(lsu_reg_pkg::preg_t r);
		return (r >> `LSU_RB) == 0;
	endfunction

	function automatic bit writes_memory(lsu_op_pkg::lsu_op_t op);
		return op.sb || op.sh || op.sw || op.sd;
	endfunction

	function automatic bit reads_memory(lsu_op_pkg::lsu_op_t op);
		return op.lb || op.lh || op.lw || op.ld || op.lbu || op.lhu || op.lwu;
	endfunction

	function automatic int size_bytes(lsu_op_pkg::lsu_op_t op);
		if (op.lb || op.lbu || op.sb) return 1;
		if (op.lh || op.lhu || op.sh) return 2;
		if (op.lw || op.lwu || op.sw) return 4;
		return 8;
	endfunction

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
		if (exp !== got) begin
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
			mismatch_count++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model stepped in program order at each accept.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic model_exec(input lsu_op_pkg::lsu_issue_info_t op_info);
		logic [63:0] addr;
		logic [63:0] val;
		int n;
		int off;
		lsu_op_pkg::mem_write_t mw;
		lsu_reg_pkg::wb_t wb;
		n    = size_bytes(op_info.op);
		addr = regs[op_info.rs1] + op_info.imm;
		off  = int'(addr[2:0]) & ~(n - 1);
		if (writes_memory(op_info.op)) begin
			mw       = '0;
			mw.valid = 1'b1;
			mw.addr  = addr[8:3];
			mw.data  = regs[op_info.rs2] << (8 * off);
			for (int b = 0; b < n; b++) begin
				mw.mask[off + b] = 1'b1;
				mem[addr[8:3]][8*(off+b) +: 8] = regs[op_info.rs2][8*b +: 8];
			end
			exp_stores.push_back(mw);
		end else if (reads_memory(op_info.op)) begin
			val = '0;
			for (int b = 0; b < n; b++) begin
				val[8*b +: 8] = mem[addr[8:3]][8*(off+b) +: 8];
			end
			// sign extension for the signed flavours.
			if (op_info.op.lb || op_info.op.lh || op_info.op.lw) begin
				for (int i = 8 * n; i < 64; i++) begin
					val[i] = val[8*n-1];
				end
			end
			if (!zero_reg(op_info.rd0)) begin
				regs[op_info.rd0] = val;
				wb = '{valid: 1'b1, rd: op_info.rd0, data: val};
				exp_loads.push_back(wb);
			end
		end
	endtask

	// sampled on the falling edge where everything is settled.
	always @(negedge CLK) begin
		lsu_reg_pkg::wb_t       wb;
		lsu_op_pkg::mem_write_t mw;
		// the queue holds every pending op except at most the one in the issue register.
		if (pending.size() < `LSU_FIFO_DP) begin
			compare("dispatch_full", 64'd0, 64'(dispatch_full));
		end else if (pending.size() > `LSU_FIFO_DP) begin
			compare("dispatch_full", 64'd1, 64'(dispatch_full));
		end
		if (ext_wb.valid && !zero_reg(ext_wb.rd)) begin
			regs[ext_wb.rd] = ext_wb.data;
		end
		if (load_wb.valid) begin
			if (exp_loads.size() == 0) begin
				$display("%0t: load write-back arrived with no load outstanding", $time);
				mismatch_count++;
			end else begin
				wb = exp_loads.pop_front();
				compare("load_wb.rd", 64'(wb.rd), 64'(load_wb.rd));
				compare("load_wb.data", wb.data, load_wb.data);
			end
		end
		if (mem_write.valid) begin
			if (exp_stores.size() == 0) begin
				$display("%0t: memory write arrived with no store outstanding", $time);
				mismatch_count++;
			end else begin
				mw = exp_stores.pop_front();
				compare("mem_write.addr", 64'(mw.addr), 64'(mem_write.addr));
				compare("mem_write.data", mw.data, mem_write.data);
				compare("mem_write.mask", 64'(mw.mask), 64'(mem_write.mask));
			end
		end
		if (issue_fire) begin
			if (pending.size() == 0) begin
				$display("%0t: execution unit accepted an operation never dispatched", $time);
				mismatch_count++;
			end else begin
				model_exec(pending.pop_front());
			end
		end
		if (flush) begin
			pending.delete();
		end else if (dispatch_valid && !dispatch_full) begin
			pending.push_back(dispatch_info);
		end
		if (end_check && !checked) begin
			checked = 1;
			if (pending.size() + exp_loads.size() + exp_stores.size() != 0) begin
				$display("%0t: run ended with %0d unissued ops, %0d loads and %0d stores missing",
					$time, pending.size(), exp_loads.size(), exp_stores.size());
				missing_count += pending.size() + exp_loads.size() + exp_stores.size();
			end
		end
		busy = (pending.size() + exp_loads.size() + exp_stores.size()) != 0;
	end

endmodule

// ==== testbench/tb_top.sv ====
module tb_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_OPS = 300;
	localparam int LIMIT = 10 + 64 + N_OPS * 12 + 200;

	logic                        CLK;
	logic                        reset;
	logic                        flush;
	logic                        dispatch_valid;
	logic                        dispatch_full;
	lsu_op_pkg::lsu_issue_info_t dispatch_info;
	lsu_reg_pkg::wb_t            ext_wb;
	lsu_reg_pkg::wb_t            load_wb;
	lsu_op_pkg::mem_write_t      mem_write;
	logic                        end_check;
	logic                        busy;
	int                          mismatch_count;
	int                          missing_count;
	logic [31:0]                 lfsr;
	int                          cycles;
	int                          n_sent;

	tb_clock tb_clock_inst (.CLK(CLK));

	lsu_top lsu_top_inst (
		.CLK            (CLK),
		.reset          (reset),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch_info  (dispatch_info),
		.dispatch_full  (dispatch_full),
		.ext_wb         (ext_wb),
		.load_wb        (load_wb),
		.mem_write      (mem_write)
	);

	tb_checker tb_checker_inst (
		.CLK            (CLK),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch_full  (dispatch_full),
		.dispatch_info  (dispatch_info),
		.ext_wb         (ext_wb),
		.issue_fire     (lsu_top_inst.issue_valid && lsu_top_inst.issue_ready),
		.load_wb        (load_wb),
		.mem_write      (mem_write),
		.end_check      (end_check),
		.busy           (busy),
		.mismatch_count (mismatch_count),
		.missing_count  (missing_count)
	);

	// 32-bit Fibonacci LFSR, taps 32 22 2 1.
	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[62:0], lfsr[0]};
		end
	endtask

	// codes 0..12 follow the flag order lb .. fence.
	function automatic lsu_op_pkg::lsu_op_t op_from_code(int code);
		return lsu_op_pkg::lsu_op_t'(13'h1000 >> code);
	endfunction

	function automatic logic [63:0] align_imm(lsu_op_pkg::lsu_op_t op, logic [63:0] v);
		if (op.ld || op.sd) return v & ~64'd7;
		if (op.lw || op.lwu || op.sw) return v & ~64'd3;
		if (op.lh || op.lhu || op.sh) return v & ~64'd1;
		return v;
	endfunction

	task automatic send_op(input lsu_op_pkg::lsu_issue_info_t info);
		logic full_now;
		dispatch_valid = 1'b1;
		dispatch_info  = info;
		do begin
			full_now = dispatch_full;
			@(posedge CLK);
			#2;
		end while (full_now);
		dispatch_valid = 1'b0;
		n_sent++;
	endtask

	task automatic wait_drained();
		@(posedge CLK);
		#2;
		while (busy) begin
			@(posedge CLK);
			#2;
		end
	endtask

	task automatic write_reg(input lsu_reg_pkg::preg_t rd, input logic [63:0] data);
		ext_wb = '{valid: 1'b1, rd: rd, data: data};
		@(posedge CLK);
		#2;
		ext_wb.valid = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bursts keep destinations apart so no reallocation blocks an older op.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic run_burst(input int max_ops);
		logic [63:0] r;
		lsu_op_pkg::lsu_issue_info_t info;
		lsu_reg_pkg::preg_t last_ld;
		bit used [64];
		bit have_ld;
		int n;
		take_bits(2, r);
		n = int'(r[1:0]) + 1;
		if (n > max_ops) n = max_ops;
		foreach (used[i]) used[i] = 0;
		used[2] = 1;
		used[3] = 1;
		have_ld = 0;
		for (int k = 0; k < n; k++) begin
			info = '0;
			take_bits(4, r);
			info.op = op_from_code(r[3:0] < 13 ? int'(r[3:0]) : 3);
			take_bits(2, r);
			if (have_ld && r[1:0] == 2'd0) begin
				info.rs1 = last_ld;
			end else begin
				take_bits(1, r);
				info.rs1 = 6'd2 + 6'(r[0]);
			end
			take_bits(6, r);
			info.rs2 = r[5:0];
			take_bits(6, r);
			info.imm = align_imm(info.op, r);
			used[info.rs1] = 1;
			if (lsu_op_pkg::is_store(info.op)) used[info.rs2] = 1;
			if (lsu_op_pkg::is_load(info.op)) begin
				do begin
					take_bits(6, r);
					info.rd0 = r[5:0];
				end while (used[info.rd0] && info.rd0[5:1] != 0);
				if (info.rd0[5:1] != 0) begin
					used[info.rd0] = 1;
					last_ld = info.rd0;
					have_ld = 1;
				end
			end
			send_op(info);
		end
		wait_drained();
	endtask

	// the two dependents are still waiting when the flush lands.
	task automatic run_flush_burst();
		logic [63:0] r;
		lsu_op_pkg::lsu_issue_info_t a;
		lsu_op_pkg::lsu_issue_info_t b;
		lsu_op_pkg::lsu_issue_info_t c;
		a = '0;
		take_bits(3, r);
		a.op  = op_from_code(r[2:0] < 7 ? int'(r[2:0]) : 3);
		a.rs1 = 6'd2;
		do begin
			take_bits(6, r);
			a.rd0 = r[5:0];
		end while (a.rd0 < 6'd4);
		b = '0;
		b.op  = op_from_code(3);
		b.rs1 = a.rd0;
		do begin
			take_bits(6, r);
			b.rd0 = r[5:0];
		end while (b.rd0 == a.rd0 || b.rd0 == 6'd2 || b.rd0 == 6'd3);
		c = '0;
		take_bits(2, r);
		c.op  = op_from_code(7 + int'(r[1:0]));
		c.rs1 = a.rd0;
		take_bits(6, r);
		c.rs2 = r[5:0];
		send_op(a);
		send_op(b);
		send_op(c);
		flush = 1'b1;
		@(posedge CLK);
		#2;
		flush = 1'b0;
		wait_drained();
		take_bits(64, r);
		write_reg(b.rd0, r);
	endtask

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		logic [63:0] r;
		reset          = 1'b1;
		flush          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_info  = '0;
		ext_wb         = '0;
		end_check      = 1'b0;
		lfsr           = 32'hea7be0b4;
		cycles         = 0;
		n_sent         = 0;
		repeat (10) @(posedge CLK);
		#2;
		reset = 1'b0;

		// preset phase, x1 of both ranks holds a base address.
		for (int p = 0; p < 64; p++) begin
			take_bits(64, r);
			if (p == 2 || p == 3) r = r & 64'h1f8;
			write_reg(6'(p), r);
		end

		while (n_sent < N_OPS) begin
			take_bits(3, r);
			if (r[2:0] == 3'd0 && n_sent <= N_OPS - 3) begin
				run_flush_burst();
			end else begin
				run_burst(N_OPS - n_sent);
			end
		end

		repeat (10) @(posedge CLK);
		#2;
		end_check = 1'b1;
		repeat (2) @(posedge CLK);
		$display("errors: %0d mismatches, %0d missing events", mismatch_count, missing_count);
		if (mismatch_count + missing_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+source
source/lsu_reg_pkg.sv
source/lsu_op_pkg.sv
source/lsu_issue_fifo.sv
source/lsu_regfile.sv
source/lsu_issue.sv
source/lsu_exec.sv
source/lsu_top.sv
testbench/tb_clock.sv
testbench/lsu_assertions.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the load/store slice testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1
